// File: common/acq_bus_macros.svh
`ifndef ACQ_BUS_MACROS_SVH
`define ACQ_BUS_MACROS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define ACQ_WB_ADDR_W 8
`define ACQ_WB_DATA_W 32
`define ACQ_WB_SEL_W 4

// One ADC sample, two of them per FIFO word
`define ACQ_ADC_W 14

// Scratch RAM, 16 words
`define ACQ_MEM_AW 4

// --------------------------------------------------
// Address map
// --------------------------------------------------
// Everything below this goes to the RAM
`define ACQ_MEM_LIMIT 8'h10
`define ACQ_SMP_ADDR 8'h20
// Returned for any unmapped address
`define ACQ_DUMMY_WORD 32'hDEAD_BEEF

`endif

// File: common/acq_bus_pkg.sv
`include "acq_bus_macros.svh"

package acq_bus_pkg;

    // --------------------------------------------------
    // Bus targets
    // --------------------------------------------------
    // Dummy is the catch-all for unmapped addresses
    typedef enum logic [1:0] {
        TGT_DUMMY = 2'd0,
        TGT_MEM   = 2'd1,
        TGT_SMP   = 2'd2
    } wb_target_e;

    // --------------------------------------------------
    // Sample word
    // --------------------------------------------------
    // Sample B in the upper half, A in the lower half
    // Each sample left aligned in its 16-bit half
    typedef struct packed {
        logic [`ACQ_ADC_W-1:0]                    smp_b;
        logic [`ACQ_WB_DATA_W/2-`ACQ_ADC_W-1:0] pad_b;
        logic [`ACQ_ADC_W-1:0]                    smp_a;
        logic [`ACQ_WB_DATA_W/2-`ACQ_ADC_W-1:0] pad_a;
    } smp_word_t;

endpackage

// File: common/wb_target_if.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

// One Wishbone pipelined connection, decoder to one target
interface wb_target_if;

    // Request side, driven by the decoder
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`ACQ_WB_ADDR_W-1:0] addr;
    logic [`ACQ_WB_DATA_W-1:0] wdata;
    logic [`ACQ_WB_SEL_W-1:0]  sel;

    // Return side, driven by the target
    logic                      stall;
    logic                      ack;
    logic [`ACQ_WB_DATA_W-1:0] rdata;

    modport master (
        output cyc, stb, we, addr, wdata, sel,
        input  stall, ack, rdata
    );

    modport target (
        input  cyc, stb, we, addr, wdata, sel,
        output stall, ack, rdata
    );

endinterface

// File: hw/acq_bus_top.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module acq_bus_top (
    input  logic                      i_sys_clk,
    input  logic                      i_sys_rst,
    // Wishbone slave port
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [`ACQ_WB_ADDR_W-1:0] i_wb_addr,
    input  logic [`ACQ_WB_DATA_W-1:0] i_wb_wdata,
    input  logic [`ACQ_WB_SEL_W-1:0]  i_wb_sel,
    output logic                      o_wb_stall,
    output logic                      o_wb_ack,
    output logic [`ACQ_WB_DATA_W-1:0] o_wb_rdata,
    // Sample stream
    input  logic                      i_smp_valid,
    input  logic [`ACQ_ADC_W-1:0]     i_smp_a,
    input  logic [`ACQ_ADC_W-1:0]     i_smp_b,
    output logic                      o_smp_ready,
    // Service request
    output logic                      o_smp_req,
    input  logic                      i_smp_req_ack
);
    import acq_bus_pkg::*;

    wb_target_e sel_tgt;
    logic       dummy_cyc;

    // One connection per real target
    wb_target_if mem_bus ();
    wb_target_if smp_bus ();

    // --------------------------------------------------
    // Decode, targets, return path
    // --------------------------------------------------
    wb_addr_decode u_decode (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst   (i_sys_rst),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_addr   (i_wb_addr),
        .i_wb_wdata  (i_wb_wdata),
        .i_wb_sel    (i_wb_sel),
        .mem_bus     (mem_bus.master),
        .smp_bus     (smp_bus.master),
        .o_dummy_cyc (dummy_cyc),
        .o_sel_tgt   (sel_tgt)
    );

    wb_scratch_mem u_mem (
        .i_sys_clk (i_sys_clk),
        .i_sys_rst (i_sys_rst),
        .bus       (mem_bus.target)
    );

    sample_rxfifo #(
        .FIFO_AW (4)
    ) u_smp_fifo (
        .i_sys_clk     (i_sys_clk),
        .i_sys_rst     (i_sys_rst),
        .bus           (smp_bus.target),
        .i_smp_valid   (i_smp_valid),
        .i_smp_a       (i_smp_a),
        .i_smp_b       (i_smp_b),
        .o_smp_ready   (o_smp_ready),
        .o_smp_req     (o_smp_req),
        .i_smp_req_ack (i_smp_req_ack)
    );

    // Also holds the dummy target
    wb_resp_mux u_resp (
        .i_sys_clk   (i_sys_clk),
        .i_sys_rst   (i_sys_rst),
        .i_sel_tgt   (sel_tgt),
        .i_dummy_cyc (dummy_cyc),
        .i_wb_stb    (i_wb_stb),
        .mem_bus     (mem_bus.target),
        .smp_bus     (smp_bus.target),
        .o_wb_stall  (o_wb_stall),
        .o_wb_ack    (o_wb_ack),
        .o_wb_rdata  (o_wb_rdata)
    );

endmodule

// File: hw/wb_addr_decode.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module wb_addr_decode (
    input  logic                      i_sys_clk,
    input  logic                      i_sys_rst,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [`ACQ_WB_ADDR_W-1:0] i_wb_addr,
    input  logic [`ACQ_WB_DATA_W-1:0] i_wb_wdata,
    input  logic [`ACQ_WB_SEL_W-1:0]  i_wb_sel,
    wb_target_if.master               mem_bus,
    wb_target_if.master               smp_bus,
    output logic                      o_dummy_cyc,
    output acq_bus_pkg::wb_target_e   o_sel_tgt
);
    import acq_bus_pkg::*;

    // Target picked from the strobe address and valid during the strobe
    wb_target_e sel_c;

    // --------------------------------------------------
    // Address compare
    // --------------------------------------------------
    always_comb begin
        if (i_wb_addr < `ACQ_MEM_LIMIT) begin
            sel_c = TGT_MEM;
        end else if (i_wb_addr == `ACQ_SMP_ADDR) begin
            sel_c = TGT_SMP;
        end else begin
            sel_c = TGT_DUMMY;
        end
    end

    // Held for the ack cycle and reloaded on every strobe
    always_ff @(posedge i_sys_clk) begin
        if (i_sys_rst) begin
            o_sel_tgt <= TGT_DUMMY;
        end else if (i_wb_cyc && i_wb_stb) begin
            o_sel_tgt <= sel_c;
        end
    end

    // --------------------------------------------------
    // Request fan-out
    // --------------------------------------------------
    // Only the chosen target sees cyc
    assign mem_bus.cyc   = i_wb_cyc && (sel_c == TGT_MEM);
    assign smp_bus.cyc   = i_wb_cyc && (sel_c == TGT_SMP);
    assign o_dummy_cyc   = i_wb_cyc && (sel_c == TGT_DUMMY);

    // Shared request lines
    assign mem_bus.stb   = i_wb_stb;
    assign mem_bus.we    = i_wb_we;
    assign mem_bus.addr  = i_wb_addr;
    assign mem_bus.wdata = i_wb_wdata;
    assign mem_bus.sel   = i_wb_sel;
    assign smp_bus.stb   = i_wb_stb;
    assign smp_bus.we    = i_wb_we;
    assign smp_bus.addr  = i_wb_addr;
    assign smp_bus.wdata = i_wb_wdata;
    assign smp_bus.sel   = i_wb_sel;

endmodule

// File: hw/wb_resp_mux.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module wb_resp_mux (
    input  logic                      i_sys_clk,
    input  logic                      i_sys_rst,
    input  acq_bus_pkg::wb_target_e   i_sel_tgt,
    input  logic                      i_dummy_cyc,
    input  logic                      i_wb_stb,
    wb_target_if.target               mem_bus,
    wb_target_if.target               smp_bus,
    output logic                      o_wb_stall,
    output logic                      o_wb_ack,
    output logic [`ACQ_WB_DATA_W-1:0] o_wb_rdata
);
    import acq_bus_pkg::*;

    logic dummy_ack;

    // --------------------------------------------------
    // Dummy target
    // --------------------------------------------------
    // Acks one cycle after a strobe to an unmapped address
    always_ff @(posedge i_sys_clk) begin
        if (i_sys_rst) begin
            dummy_ack <= 1'b0;
        end else begin
            dummy_ack <= i_dummy_cyc && i_wb_stb;
        end
    end

    // --------------------------------------------------
    // Return routing
    // --------------------------------------------------
    // Registered select names the target being acked
    always_comb begin
        case (i_sel_tgt)
            TGT_MEM: begin
                o_wb_stall = mem_bus.stall;
                o_wb_ack   = mem_bus.ack;
                o_wb_rdata = mem_bus.rdata;
            end
            TGT_SMP: begin
                o_wb_stall = smp_bus.stall;
                o_wb_ack   = smp_bus.ack;
                o_wb_rdata = smp_bus.rdata;
            end
            default: begin
                // Dummy never stalls
                o_wb_stall = 1'b0;
                o_wb_ack   = dummy_ack;
                o_wb_rdata = `ACQ_DUMMY_WORD;
            end
        endcase
    end

endmodule

// File: hw/wb_scratch_mem.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module wb_scratch_mem (
    input  logic        i_sys_clk,
    input  logic        i_sys_rst,
    wb_target_if.target bus
);

    localparam int WORDS = 1 << `ACQ_MEM_AW;

    // Word storage
    logic [`ACQ_WB_DATA_W-1:0] mem [WORDS];

    logic                   req;
    logic [`ACQ_MEM_AW-1:0] word_addr;

    // Accepted request, stall is never raised
    assign req       = bus.cyc && bus.stb;
    assign word_addr = bus.addr[`ACQ_MEM_AW-1:0];
    assign bus.stall = 1'b0;

    // --------------------------------------------------
    // Array access
    // --------------------------------------------------
    // Writes go per byte lane under sel
    // Reads land in rdata for the ack cycle
    always_ff @(posedge i_sys_clk) begin
        if (req) begin
            if (bus.we) begin
                for (int i = 0; i < `ACQ_WB_SEL_W; i++) begin
                    if (bus.sel[i]) begin
                        mem[word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
                    end
                end
            end else begin
                bus.rdata <= mem[word_addr];
            end
        end
    end

    // Ack one cycle after acceptance, reads and writes alike
    always_ff @(posedge i_sys_clk) begin
        if (i_sys_rst) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= req;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile and run the acq_bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_acq_bus -o tb_acq_bus
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_acq_bus)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "=== PASS ==="; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

// File: sample_fifo/sample_rxfifo.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module sample_rxfifo #(
    parameter int FIFO_AW = 4
) (
    input  logic                 i_sys_clk,
    input  logic                 i_sys_rst,
    wb_target_if.target          bus,
    input  logic                 i_smp_valid,
    input  logic [`ACQ_ADC_W-1:0] i_smp_a,
    input  logic [`ACQ_ADC_W-1:0] i_smp_b,
    output logic                 o_smp_ready,
    output logic                 o_smp_req,
    input  logic                 i_smp_req_ack
);
    import acq_bus_pkg::*;

    // Count levels, full is the depth itself
    localparam logic [FIFO_AW:0] CNT_FULL = {1'b1, {FIFO_AW{1'b0}}};
    localparam logic [FIFO_AW:0] CNT_HALF = CNT_FULL >> 1;

    smp_word_t fifo_mem [1 << FIFO_AW];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    smp_word_t          smp_word;
    logic               push;
    logic               rd_req;
    logic               pop;

    // Pack the pair, pad bits stay zero
    always_comb begin
        smp_word       = '0;
        smp_word.smp_b = i_smp_b;
        smp_word.smp_a = i_smp_a;
    end

    // Stream side takes nothing while full
    assign o_smp_ready = (count != CNT_FULL);
    assign push        = i_smp_valid && o_smp_ready;

    // Bus reads pop the head; writes are acked and dropped
    assign rd_req    = bus.cyc && bus.stb && !bus.we;
    assign pop       = rd_req && (count != '0);
    assign bus.stall = 1'b0;

    // --------------------------------------------------
    // Storage and read data
    // --------------------------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= smp_word;
        end
        // Empty read returns zero
        if (rd_req) begin
            bus.rdata <= pop ? fifo_mem[rd_ptr] : '0;
        end
    end

    // --------------------------------------------------
    // Pointers, count, ack, service request
    // --------------------------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (i_sys_rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            bus.ack   <= 1'b0;
            o_smp_req <= 1'b0;
        end else begin
            bus.ack <= bus.cyc && bus.stb;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky while half full, host ack clears it below half
            if (count >= CNT_HALF) begin
                o_smp_req <= 1'b1;
            end else if (i_smp_req_ack) begin
                o_smp_req <= 1'b0;
            end
        end
    end

endmodule

// File: sources.f
+incdir+common
common/acq_bus_pkg.sv
common/wb_target_if.sv
hw/wb_addr_decode.sv
hw/wb_resp_mux.sv
hw/wb_scratch_mem.sv
sample_fifo/sample_rxfifo.sv
hw/acq_bus_top.sv
tests/tb_acq_bus.sv

// File: tests/tb_acq_bus.sv
`timescale 1ns/100ps

`include "acq_bus_macros.svh"

module tb_acq_bus;

    // Step kinds
    localparam int K_WR      = 0;
    localparam int K_RD      = 1;
    localparam int K_PUSH    = 2;
    localparam int K_REQ_ACK = 3;
    localparam int K_REQ_CHK = 4;

    localparam int ACK_TIMEOUT = 20;

    typedef struct {
        int          kind;
        logic [7:0]  addr;
        logic [31:0] data;
        logic [3:0]  sel;
        logic [13:0] smp_a;
        logic [13:0] smp_b;
        logic [31:0] exp;
    } step_t;

    logic                      sys_clk;
    logic                      sys_rst;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`ACQ_WB_ADDR_W-1:0] wb_addr;
    logic [`ACQ_WB_DATA_W-1:0] wb_wdata;
    logic [`ACQ_WB_SEL_W-1:0]  wb_sel;
    logic                      o_wb_stall;
    logic                      o_wb_ack;
    logic [`ACQ_WB_DATA_W-1:0] o_wb_rdata;
    logic                      smp_valid;
    logic [`ACQ_ADC_W-1:0]     smp_a;
    logic [`ACQ_ADC_W-1:0]     smp_b;
    logic                      o_smp_ready;
    logic                      o_smp_req;
    logic                      smp_req_ack;

    // Stimulus table and the models that fill its expected column
    step_t       steps[$];
    logic [31:0] mem_model [16];
    logic [31:0] fifo_model[$];
    logic [31:0] lfsr_state;
    int          err_data;
    int          err_proto;

    acq_bus_top u_dut (
        .i_sys_clk     (sys_clk),
        .i_sys_rst     (sys_rst),
        .i_wb_cyc      (wb_cyc),
        .i_wb_stb      (wb_stb),
        .i_wb_we       (wb_we),
        .i_wb_addr     (wb_addr),
        .i_wb_wdata    (wb_wdata),
        .i_wb_sel      (wb_sel),
        .o_wb_stall    (o_wb_stall),
        .o_wb_ack      (o_wb_ack),
        .o_wb_rdata    (o_wb_rdata),
        .i_smp_valid   (smp_valid),
        .i_smp_a       (smp_a),
        .i_smp_b       (smp_b),
        .o_smp_ready   (o_smp_ready),
        .o_smp_req     (o_smp_req),
        .i_smp_req_ack (smp_req_ack)
    );

    always #5 sys_clk = ~sys_clk;

    // --------------------------------------------------
    // Sample source and packing
    // --------------------------------------------------
    // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            val        = {val[30:0], lfsr_state[31]};
            lfsr_state = {lfsr_state[30:0], fb};
        end
        return val;
    endfunction

    // B on top, A below, two zero bits under each
    function automatic logic [31:0] pack_pair(input logic [13:0] a, input logic [13:0] b);
        return {b, 2'b00, a, 2'b00};
    endfunction

    // --------------------------------------------------
    // Table building
    // --------------------------------------------------
    function automatic void add_write(input logic [7:0] addr, input logic [31:0] data,
                                      input logic [3:0] sel);
        step_t s;
        s = '{K_WR, addr, data, sel, 14'd0, 14'd0, 32'd0};
        // Byte-lane merge into the RAM model
        if (addr < 8'h10) begin
            for (int i = 0; i < 4; i++) begin
                if (sel[i]) begin
                    mem_model[addr[3:0]][8*i +: 8] = data[8*i +: 8];
                end
            end
        end
        steps.push_back(s);
    endfunction

    function automatic void add_read(input logic [7:0] addr);
        step_t s;
        s = '{K_RD, addr, 32'd0, 4'hf, 14'd0, 14'd0, 32'd0};
        if (addr < 8'h10) begin
            s.exp = mem_model[addr[3:0]];
        end else if (addr == 8'h20) begin
            s.exp = (fifo_model.size() > 0) ? fifo_model.pop_front() : 32'd0;
        end else begin
            s.exp = 32'hDEAD_BEEF;
        end
        steps.push_back(s);
    endfunction

    // Expected column holds ready; a full FIFO drops the pair
    function automatic void add_push();
        step_t       s;
        logic [31:0] bits;
        s       = '{K_PUSH, 8'h00, 32'd0, 4'h0, 14'd0, 14'd0, 32'd0};
        bits    = take_bits(14);
        s.smp_a = bits[13:0];
        bits    = take_bits(14);
        s.smp_b = bits[13:0];
        s.exp   = (fifo_model.size() < 16) ? 32'd1 : 32'd0;
        if (s.exp[0]) begin
            fifo_model.push_back(pack_pair(s.smp_a, s.smp_b));
        end
        steps.push_back(s);
    endfunction

    function automatic void add_req(input int kind, input logic exp_req);
        step_t s;
        s = '{kind, 8'h00, 32'd0, 4'h0, 14'd0, 14'd0, {31'd0, exp_req}};
        steps.push_back(s);
    endfunction

    function automatic void build_table();
        // Scratch RAM full words then partial words
        add_write(8'h00, 32'h1234_5678, 4'hf);
        add_write(8'h05, 32'hA5A5_0F0F, 4'hf);
        add_write(8'h0f, 32'h0102_0304, 4'hf);
        add_write(8'h00, 32'hFFEE_DDCC, 4'b0101);
        add_write(8'h0f, 32'h7700_0000, 4'b1000);
        add_write(8'h05, 32'h0000_3C00, 4'b0010);
        add_read(8'h00);
        add_read(8'h05);
        add_read(8'h0f);
        // FIFO order and packing
        for (int i = 0; i < 4; i++) begin
            add_push();
        end
        for (int i = 0; i < 4; i++) begin
            add_read(8'h20);
        end
        // Empty read then a write that must change nothing
        add_read(8'h20);
        add_push();
        add_push();
        add_write(8'h20, 32'h0BAD_F00D, 4'hf);
        for (int i = 0; i < 3; i++) begin
            add_read(8'h20);
        end
        // Unmapped addresses
        add_read(8'h40);
        add_write(8'h40, 32'h5555_AAAA, 4'hf);
        add_read(8'h80);
        add_read(8'hff);
        // Service request stays sticky until acked below half
        for (int i = 0; i < 7; i++) begin
            add_push();
        end
        add_req(K_REQ_CHK, 1'b0);
        add_push();
        add_req(K_REQ_CHK, 1'b1);
        add_req(K_REQ_ACK, 1'b1);
        add_read(8'h20);
        add_req(K_REQ_CHK, 1'b1);
        add_req(K_REQ_ACK, 1'b0);
        for (int i = 0; i < 7; i++) begin
            add_read(8'h20);
        end
        add_req(K_REQ_CHK, 1'b0);
        // Back-pressure with two pairs beyond full
        for (int i = 0; i < 18; i++) begin
            add_push();
        end
        for (int i = 0; i < 17; i++) begin
            add_read(8'h20);
        end
    endfunction

    // --------------------------------------------------
    // Step drivers
    // --------------------------------------------------
    task automatic bus_access(input step_t s);
        int          waited;
        logic        got_ack;
        logic [31:0] rdata;
        @(posedge sys_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= (s.kind == K_WR);
        wb_addr  <= s.addr;
        wb_wdata <= s.data;
        wb_sel   <= s.sel;
        @(negedge sys_clk);
        assert (o_wb_stall === 1'b0) else begin
            $display("** Error %0t: stall raised, addr %h", $time, s.addr);
            err_data++;
        end
        // Accepted on this edge
        @(posedge sys_clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        waited  = 0;
        got_ack = 1'b0;
        rdata   = '0;
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge sys_clk);
            waited++;
            got_ack = (o_wb_ack === 1'b1);
            rdata   = o_wb_rdata;
        end
        assert (got_ack) else begin
            $display("No ack came back for address %h within %0d cycles",
                     s.addr, ACK_TIMEOUT);
            err_proto++;
        end
        assert (!got_ack || waited == 1) else begin
            $display("** Error %0t: ack after %0d cycles, addr %h", $time, waited, s.addr);
            err_data++;
        end
        if (got_ack && s.kind == K_RD) begin
            assert (rdata === s.exp) else begin
                $display("** Error %0t: read %h got %h, expected %h",
                         $time, s.addr, rdata, s.exp);
                err_data++;
            end
        end
        // Exactly one ack per request
        @(negedge sys_clk);
        assert (o_wb_ack === 1'b0) else begin
            $display("** Error %0t: extra ack, addr %h", $time, s.addr);
            err_data++;
        end
    endtask

    task automatic push_pair(input step_t s);
        @(posedge sys_clk);
        smp_valid <= 1'b1;
        smp_a     <= s.smp_a;
        smp_b     <= s.smp_b;
        @(negedge sys_clk);
        assert (o_smp_ready === s.exp[0]) else begin
            $display("** Error %0t: ready is %b, expected %b", $time, o_smp_ready, s.exp[0]);
            err_data++;
        end
        @(posedge sys_clk);
        smp_valid <= 1'b0;
    endtask

    task automatic req_step(input step_t s);
        @(posedge sys_clk);
        if (s.kind == K_REQ_ACK) begin
            smp_req_ack <= 1'b1;
        end
        @(posedge sys_clk);
        smp_req_ack <= 1'b0;
        @(negedge sys_clk);
        assert (o_smp_req === s.exp[0]) else begin
            $display("** Error %0t: service request is %b, expected %b",
                     $time, o_smp_req, s.exp[0]);
            err_data++;
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        sys_clk     = 1'b0;
        sys_rst     = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_addr     = '0;
        wb_wdata    = '0;
        wb_sel      = '0;
        smp_valid   = 1'b0;
        smp_a       = '0;
        smp_b       = '0;
        smp_req_ack = 1'b0;
        err_data    = 0;
        err_proto   = 0;
        lfsr_state  = 32'hb46f;
        build_table();

        repeat (3) @(posedge sys_clk);
        sys_rst <= 1'b0;
        @(negedge sys_clk);
        assert (!o_wb_ack && !o_wb_stall && !o_smp_req && o_smp_ready) else begin
            $display("Outputs after reset are not ack, stall and request low with ready high");
            err_proto++;
        end

        foreach (steps[i]) begin
            case (steps[i].kind)
                K_WR, K_RD: bus_access(steps[i]);
                K_PUSH:     push_pair(steps[i]);
                default:    req_step(steps[i]);
            endcase
        end

        $display("Steps %0d, value errors %0d, other errors %0d",
                 steps.size(), err_data, err_proto);
        if (err_data == 0 && err_proto == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
